/* src.f */
verilog/fetch_pkg.sv
verilog/mem_controller.sv
verilog/ins_cache.sv
verilog/predictor.sv
verilog/instruction_fetcher.sv
verilog/decoder.sv
verilog/cpu_front_end.sv
bench/tb_ram.sv
bench/tb_front_end.sv

/* Bender.yml */
package:
  name: cpu_front_end

sources:
  - verilog/fetch_pkg.sv
  - verilog/mem_controller.sv
  - verilog/ins_cache.sv
  - verilog/predictor.sv
  - verilog/instruction_fetcher.sv
  - verilog/decoder.sv
  - verilog/cpu_front_end.sv
  - target: test
    files:
      - bench/tb_ram.sv
      - bench/tb_front_end.sv

/* bench/tb_front_end.sv */
// front end testbench with clock, reset, program load, stimulus, reference model and checks
`timescale 1ns/1ps

module tb_front_end;

  localparam int N_INST      = 48;  // loop length in words
  localparam int ROUNDS      = 8;
  localparam int ROUND_ITEMS = 40;
  localparam int MAX_CYCLES  = (2 * N_INST + ROUNDS * ROUND_ITEMS + 16) * 40;
  localparam logic [8*7-1:0] OPS = {fetch_pkg::OP_REG, fetch_pkg::OP_IMM, fetch_pkg::OP_STORE,
                                    fetch_pkg::OP_BRANCH, fetch_pkg::OP_LOAD, fetch_pkg::OP_JALR,
                                    fetch_pkg::OP_AUIPC, fetch_pkg::OP_LUI};

  logic                 clk_in;
  logic                 rst_in;
  logic                 rdy_in;
  logic                 dec_stall;
  logic [7:0]           mem_din;
  logic [31:0]          mem_a;
  fetch_pkg::redirect_t redirect;
  fetch_pkg::feedback_t fb;
  fetch_pkg::decoded_t  dec;
  logic                 dec_valid;

  logic [1:0]          mirror [256];  // copy of the predictor table
  int                  branch_idx [$];
  logic [31:0]         exp_pc;
  int                  consumed;
  int                  errors;
  int                  checks;
  int                  cycles;
  int                  passes;
  logic                phase1;
  logic                watch;
  logic [31:0]         mem_a_ref;
  fetch_pkg::decoded_t prev_dec;
  logic                prev_valid;
  logic                prev_held;
  logic                prev_frozen;
  logic [31:0]         prev_mem_a;

  cpu_front_end i_dut (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .rdy_in   (rdy_in),
    .mem_din  (mem_din),
    .mem_a    (mem_a),
    .redirect (redirect),
    .fb       (fb),
    .dec_stall(dec_stall),
    .dec      (dec),
    .dec_valid(dec_valid)
  );

  tb_ram #(
    .ADDR_BITS(fetch_pkg::MEM_ADDR_BITS)
  ) i_ram (
    .clk_in(clk_in),
    .rdy_in(rdy_in),
    .a     (mem_a),
    .dout  (mem_din)
  );

  initial begin
    clk_in = 1'b0;
    forever #50 clk_in = ~clk_in;
  end

  task automatic report(input string msg);
    errors++;
    $display("error %0t: %s", $time, msg);
  endtask

  // field extraction straight from the rv32i bit layout
  function automatic fetch_pkg::decoded_t expect_decode(logic [31:0] pc, logic [31:0] w,
                                                       logic pt);
    fetch_pkg::decoded_t d;
    d.pc         = pc;
    d.opcode     = w[6:0];
    d.funct3     = w[14:12];
    d.funct7     = w[31:25];
    d.rd         = w[11:7];
    d.rs1        = w[19:15];
    d.rs2        = '0;
    d.imm        = '0;
    d.pred_taken = pt;
    case (w[6:0])
      fetch_pkg::OP_LUI, fetch_pkg::OP_AUIPC: d.imm = {w[31:12], 12'b0};
      fetch_pkg::OP_JAL: d.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
      fetch_pkg::OP_JALR, fetch_pkg::OP_LOAD, fetch_pkg::OP_IMM: d.imm = {{20{w[31]}}, w[31:20]};
      fetch_pkg::OP_STORE: begin
        d.imm = {{20{w[31]}}, w[31:25], w[11:7]};
        d.rs2 = w[24:20];
        d.rd  = '0;
      end
      fetch_pkg::OP_BRANCH: begin
        d.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        d.rs2 = w[24:20];
        d.rd  = '0;
      end
      fetch_pkg::OP_REG: d.rs2 = w[24:20];
      default: d.imm = '0;
    endcase
    return d;
  endfunction

  function automatic logic [31:0] next_expected(logic [31:0] pc, logic [31:0] w, logic taken);
    fetch_pkg::decoded_t d;
    d = expect_decode(pc, w, taken);
    if (w[6:0] == fetch_pkg::OP_JAL || (w[6:0] == fetch_pkg::OP_BRANCH && taken)) begin
      return pc + d.imm;
    end
    return pc + 32'd4;
  endfunction

  // loop of mixed opcodes closed by a jal back to 0
  task automatic load_program();
    logic [6:0]  op;
    logic [31:0] w;
    logic [12:0] boff;
    logic [20:0] joff;
    int          tgt;
    for (int i = 0; i < N_INST - 1; i++) begin
      op = OPS[7*(i % 8) +: 7];
      w  = $urandom;
      if (op == fetch_pkg::OP_BRANCH) begin
        tgt = $urandom % N_INST;
        if (tgt == i) begin
          tgt = i + 1;  // no self loop
        end
        boff = 13'((tgt - i) * 4);
        w    = {boff[12], boff[10:5], w[24:12], boff[4:1], boff[11], op};
        branch_idx.push_back(i);
      end else begin
        w = {w[31:7], op};
      end
      i_ram.write_word(32'(i * 4), w);
    end
    joff = 21'(-(N_INST - 1) * 4);
    w    = $urandom;
    w    = {joff[20], joff[10:1], joff[11], joff[19:12], w[11:7], fetch_pkg::OP_JAL};
    i_ram.write_word(32'((N_INST - 1) * 4), w);
  endtask

  // stall, redirect and one feedback on the same edge so nothing in flight sees it
  task automatic redirect_round();
    logic [31:0] target;
    int          bi;
    logic        taken;
    target = 32'(($urandom % N_INST) * 4);
    bi     = branch_idx[$urandom % branch_idx.size()];
    taken  = ($urandom % 4) != 0;
    @(posedge clk_in);
    dec_stall <= 1'b1;
    rdy_in    <= 1'b1;
    @(posedge clk_in);
    redirect.en    <= 1'b1;
    redirect.pc    <= target;
    fb.fb_en       <= 1'b1;
    fb.fb_pc       <= 32'(bi * 4);
    fb.fb_taken    <= taken;
    exp_pc = target;
    if (taken && mirror[bi] != 2'b11) begin
      mirror[bi] = mirror[bi] + 2'b01;
    end else if (!taken && mirror[bi] != 2'b00) begin
      mirror[bi] = mirror[bi] - 2'b01;
    end
    @(posedge clk_in);
    redirect <= '0;
    fb       <= '0;
    repeat (3) @(posedge clk_in);
  endtask

  always @(negedge clk_in) begin : check_outputs
    fetch_pkg::decoded_t want;
    logic [31:0]         w;
    if (!rst_in) begin
      if (prev_frozen) begin
        assert (dec_valid == prev_valid && dec == prev_dec && mem_a == prev_mem_a)
        else report("outputs moved while rdy_in was low");
      end else if (prev_held) begin
        assert (dec_valid && dec == prev_dec) else report("dec changed while stalled");
      end
      if (watch) begin
        assert (mem_a == mem_a_ref)
        else report($sformatf("mem_a moved to %h on cached pass", mem_a));
      end
      if (dec_valid && !dec_stall && rdy_in) begin
        w    = i_ram.read_word(exp_pc);
        want = expect_decode(exp_pc, w, mirror[exp_pc[9:2]][1]);
        checks++;
        assert (dec == want)
        else report($sformatf("item got %h want %h (pc %h)", dec, want, exp_pc));
        if (exp_pc == 32'(fetch_pkg::RESET_PC)) begin
          passes++;
          if (phase1 && passes == 2) begin
            watch     = 1'b1;
            mem_a_ref = mem_a;
          end
        end
        if (watch && exp_pc == 32'((N_INST - 1) * 4)) begin
          watch = 1'b0;
        end
        exp_pc = next_expected(exp_pc, w, mirror[exp_pc[9:2]][1]);
        consumed++;
      end
    end
    prev_frozen = !rdy_in;
    prev_held   = dec_valid && dec_stall && rdy_in && !redirect.en;
    prev_valid  = dec_valid;
    prev_dec    = dec;
    prev_mem_a  = mem_a;
  end

  always @(posedge clk_in) begin
    cycles <= cycles + 1;
    if (cycles > MAX_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'h0259507b));
    rst_in    = 1'b1;
    rdy_in    = 1'b1;
    dec_stall = 1'b0;
    redirect  = '0;
    fb        = '0;
    exp_pc    = fetch_pkg::RESET_PC;
    consumed  = 0;
    errors    = 0;
    checks    = 0;
    cycles    = 0;
    passes    = 0;
    phase1    = 1'b1;
    watch     = 1'b0;
    prev_frozen = 1'b0;
    prev_held   = 1'b0;
    for (int i = 0; i < 256; i++) begin
      mirror[i] = 2'b01;  // weakly not taken
    end
    @(posedge clk_in);
    load_program();
    repeat (14) @(posedge clk_in);
    @(negedge clk_in);
    assert (!dec_valid) else report("dec_valid high at end of reset");
    @(posedge clk_in);
    rst_in <= 1'b0;
    // straight line twice so the second pass runs from the cache
    while (consumed < 2 * N_INST + 2) begin
      @(posedge clk_in);
      dec_stall <= ($urandom % 4) == 0;
    end
    phase1 = 1'b0;
    assert (!watch && passes >= 2)
    else report("second pass through the loop was not completed");
    watch = 1'b0;
    for (int r = 0; r < ROUNDS; r++) begin
      redirect_round();
      while (consumed < 2 * N_INST + 2 + (r + 1) * ROUND_ITEMS) begin
        @(posedge clk_in);
        dec_stall <= ($urandom % 4) == 0;
        rdy_in    <= ($urandom % 8) != 0;
      end
    end
    @(posedge clk_in);
    $display("checks %0d errors %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* bench/tb_ram.sv */
// byte ram model with one cycle read latency, address-based fill and word access helpers
`timescale 1ns/1ps

module tb_ram #(
  parameter int ADDR_BITS = 17
) (
  input  logic        clk_in,
  input  logic        rdy_in,
  input  logic [31:0] a,
  output logic [7:0]  dout
);

  logic [7:0] mem [1 << ADDR_BITS];

  // fill pattern folds every address bit into the byte
  initial begin
    for (int i = 0; i < (1 << ADDR_BITS); i++) begin
      mem[i] = 8'(i ^ (i >> 8) ^ (i >> 16));
    end
  end

  // frozen together with the rest of the system
  always_ff @(posedge clk_in) begin
    if (rdy_in) begin
      dout <= mem[a[ADDR_BITS-1:0]];
    end
  end

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
    for (int k = 0; k < 4; k++) begin
      mem[(addr + k) % (1 << ADDR_BITS)] = data[8*k +: 8];  // little endian
    end
  endtask

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    logic [31:0] w;
    for (int k = 0; k < 4; k++) begin
      w[8*k +: 8] = mem[(addr + k) % (1 << ADDR_BITS)];
    end
    return w;
  endfunction

endmodule

/* verilog/cpu_front_end.sv */
// front end top with memory controller, icache, fetcher, predictor and decoder
`timescale 1ns/1ps

module cpu_front_end #(
  parameter int ADDR_WIDTH    = fetch_pkg::ADDR_WIDTH,
  parameter int MEM_ADDR_BITS = fetch_pkg::MEM_ADDR_BITS,
  parameter int BLOCK_WIDTH   = fetch_pkg::BLOCK_WIDTH,
  parameter int CACHE_WIDTH   = fetch_pkg::CACHE_WIDTH,
  parameter int PRED_WIDTH    = fetch_pkg::PRED_WIDTH,
  parameter logic [fetch_pkg::ADDR_WIDTH-1:0] RESET_PC = fetch_pkg::RESET_PC
) (
  input  logic                  clk_in,
  input  logic                  rst_in,
  input  logic                  rdy_in,      // freezes everything when low
  input  logic [7:0]            mem_din,
  output logic [ADDR_WIDTH-1:0] mem_a,
  input  fetch_pkg::redirect_t  redirect,
  input  fetch_pkg::feedback_t  fb,
  input  logic                  dec_stall,
  output fetch_pkg::decoded_t   dec,
  output logic                  dec_valid
);

  fetch_pkg::fetch_req_t            req;
  fetch_pkg::fetch_rsp_t            rsp;
  logic                             fill_en;
  logic [fetch_pkg::ADDR_WIDTH-1:0] fill_addr;
  logic                             fill_done;
  fetch_pkg::block_t                fill_block;
  logic [fetch_pkg::ADDR_WIDTH-1:0] pred_pc;
  logic                             pred_taken;
  fetch_pkg::fetched_t              fetched;
  logic                             fetched_valid;

  mem_controller #(
    .ADDR_WIDTH   (ADDR_WIDTH),
    .MEM_ADDR_BITS(MEM_ADDR_BITS)
  ) i_mem_controller (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .rdy_in    (rdy_in),
    .fill_en   (fill_en),
    .fill_addr (fill_addr),
    .fill_done (fill_done),
    .fill_block(fill_block),
    .mem_din   (mem_din),
    .mem_a     (mem_a)
  );

  ins_cache #(
    .BLOCK_WIDTH(BLOCK_WIDTH),
    .CACHE_WIDTH(CACHE_WIDTH)
  ) i_ins_cache (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .rdy_in    (rdy_in),
    .req       (req),
    .rsp       (rsp),
    .fill_en   (fill_en),
    .fill_addr (fill_addr),
    .fill_done (fill_done),
    .fill_block(fill_block)
  );

  predictor #(
    .PRED_WIDTH(PRED_WIDTH)
  ) i_predictor (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .rdy_in    (rdy_in),
    .pc        (pred_pc),
    .pred_taken(pred_taken),
    .fb        (fb)
  );

  instruction_fetcher #(
    .RESET_PC(RESET_PC)
  ) i_instruction_fetcher (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .rdy_in       (rdy_in),
    .req          (req),
    .rsp          (rsp),
    .pred_pc      (pred_pc),
    .pred_taken   (pred_taken),
    .redirect     (redirect),
    .fetched      (fetched),
    .fetched_valid(fetched_valid),
    .dec_stall    (dec_stall)
  );

  decoder i_decoder (
    .fetched      (fetched),
    .fetched_valid(fetched_valid),
    .dec          (dec),
    .dec_valid    (dec_valid)
  );

endmodule

/* verilog/decoder.sv */
// combinational field and immediate extraction for the fetched instruction
`timescale 1ns/1ps

module decoder (
  input  fetch_pkg::fetched_t fetched,
  input  logic                fetched_valid,
  output fetch_pkg::decoded_t dec,
  output logic                dec_valid
);

  fetch_pkg::inst_word_u w;

  assign w         = fetched.inst;
  assign dec_valid = fetched_valid;

  always_comb begin
    dec.pc         = fetched.pc;
    dec.pred_taken = fetched.pred_taken;
    dec.opcode     = w.r.opcode;
    dec.funct3     = w.r.funct3;
    dec.funct7     = w.r.funct7;  // shift immediates need it as well
    dec.rs1        = w.r.rs1;
    dec.rd         = w.r.rd;
    dec.rs2        = '0;
    dec.imm        = '0;
    case (w.r.opcode)
      fetch_pkg::OP_LUI,
      fetch_pkg::OP_AUIPC: dec.imm = fetch_pkg::imm_u(w);
      fetch_pkg::OP_JAL: dec.imm = fetch_pkg::imm_j(w);
      fetch_pkg::OP_JALR,
      fetch_pkg::OP_LOAD,
      fetch_pkg::OP_IMM: dec.imm = fetch_pkg::imm_i(w);
      fetch_pkg::OP_STORE: begin
        dec.imm = fetch_pkg::imm_s(w);
        dec.rs2 = w.s.rs2;
        dec.rd  = '0;  // imm bits live there
      end
      fetch_pkg::OP_BRANCH: begin
        dec.imm = fetch_pkg::imm_b(w);
        dec.rs2 = w.b.rs2;
        dec.rd  = '0;
      end
      fetch_pkg::OP_REG: dec.rs2 = w.r.rs2;
      default: dec.imm = '0;
    endcase
  end

endmodule

/* verilog/instruction_fetcher.sv */
// pc register, next-pc choice, redirect handling and output holding register
`timescale 1ns/1ps

module instruction_fetcher #(
  parameter logic [fetch_pkg::ADDR_WIDTH-1:0] RESET_PC = fetch_pkg::RESET_PC
) (
  input  logic                             clk_in,
  input  logic                             rst_in,
  input  logic                             rdy_in,
  output fetch_pkg::fetch_req_t            req,
  input  fetch_pkg::fetch_rsp_t            rsp,
  output logic [fetch_pkg::ADDR_WIDTH-1:0] pred_pc,
  input  logic                             pred_taken,
  input  fetch_pkg::redirect_t             redirect,
  output fetch_pkg::fetched_t              fetched,
  output logic                             fetched_valid,
  input  logic                             dec_stall
);

  logic [fetch_pkg::ADDR_WIDTH-1:0] pc_q;
  logic [fetch_pkg::ADDR_WIDTH-1:0] next_pc;
  fetch_pkg::inst_word_u            inst;
  logic                             take;

  assign inst = rsp.inst;

  // no fetch for a pc that is about to be replaced
  assign req.en  = !redirect.en;
  assign req.pc  = pc_q;
  assign pred_pc = pc_q;

  // holding register empty, or drained on this edge
  assign take = rsp.hit && (!fetched_valid || !dec_stall);

  always_comb begin
    next_pc = pc_q + 32'd4;  // jalr falls through too
    if (inst.r.opcode == fetch_pkg::OP_JAL) begin
      next_pc = pc_q + fetch_pkg::imm_j(inst);
    end else if (inst.r.opcode == fetch_pkg::OP_BRANCH && pred_taken) begin
      next_pc = pc_q + fetch_pkg::imm_b(inst);
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      pc_q          <= RESET_PC;
      fetched_valid <= 1'b0;
    end else if (rdy_in) begin
      if (redirect.en) begin
        pc_q          <= redirect.pc;
        fetched_valid <= 1'b0;  // drop the old stream
      end else if (take) begin
        pc_q          <= next_pc;
        fetched_valid <= 1'b1;
      end else if (!dec_stall) begin
        fetched_valid <= 1'b0;  // consumed, nothing behind it
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rdy_in && take) begin
      fetched.pc         <= pc_q;
      fetched.inst       <= rsp.inst;
      fetched.pred_taken <= pred_taken;
    end
  end

endmodule

/* verilog/predictor.sv */
// two-bit saturating counter table with pc lookup and feedback update
`timescale 1ns/1ps

module predictor #(
  parameter int PRED_WIDTH = fetch_pkg::PRED_WIDTH
) (
  input  logic                             clk_in,
  input  logic                             rst_in,
  input  logic                             rdy_in,
  input  logic [fetch_pkg::ADDR_WIDTH-1:0] pc,
  output logic                             pred_taken,
  input  fetch_pkg::feedback_t             fb
);

  localparam int ENTRIES = 1 << PRED_WIDTH;

  logic [1:0]            cnt_q [ENTRIES];
  logic [PRED_WIDTH-1:0] fb_idx;
  logic [1:0]            fb_cnt;

  assign pred_taken = cnt_q[pc[PRED_WIDTH+1:2]][1];  // upper bit is the guess
  assign fb_idx     = fb.fb_pc[PRED_WIDTH+1:2];
  assign fb_cnt     = cnt_q[fb_idx];

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      for (int i = 0; i < ENTRIES; i++) begin
        cnt_q[i] <= 2'b01;  // weakly not taken
      end
    end else if (rdy_in && fb.fb_en) begin
      if (fb.fb_taken && fb_cnt != 2'b11) begin
        cnt_q[fb_idx] <= fb_cnt + 2'b01;
      end else if (!fb.fb_taken && fb_cnt != 2'b00) begin
        cnt_q[fb_idx] <= fb_cnt - 2'b01;
      end
    end
  end

endmodule

/* verilog/ins_cache.sv */
// direct-mapped instruction cache with tag and valid arrays and block fill on miss
`timescale 1ns/1ps

module ins_cache #(
  parameter int BLOCK_WIDTH = fetch_pkg::BLOCK_WIDTH,
  parameter int CACHE_WIDTH = fetch_pkg::CACHE_WIDTH
) (
  input  logic                              clk_in,
  input  logic                              rst_in,
  input  logic                              rdy_in,
  input  fetch_pkg::fetch_req_t             req,
  output fetch_pkg::fetch_rsp_t             rsp,
  output logic                              fill_en,
  output logic [fetch_pkg::ADDR_WIDTH-1:0]  fill_addr,
  input  logic                              fill_done,
  input  fetch_pkg::block_t                 fill_block
);

  localparam int AW     = fetch_pkg::ADDR_WIDTH;
  localparam int IDX_LO = BLOCK_WIDTH + 2;
  localparam int TAG_LO = CACHE_WIDTH + BLOCK_WIDTH + 2;
  localparam int BLOCKS = 1 << CACHE_WIDTH;

  fetch_pkg::block_t  data_q [BLOCKS];
  logic [AW-1:TAG_LO] tag_q [BLOCKS];
  logic [BLOCKS-1:0]  valid_q;

  logic [CACHE_WIDTH-1:0] req_idx;
  logic [BLOCK_WIDTH-1:0] req_off;   // word within block
  logic [CACHE_WIDTH-1:0] fill_idx;
  logic                   hit;

  assign req_idx  = req.pc[TAG_LO-1:IDX_LO];
  assign req_off  = req.pc[IDX_LO-1:2];
  assign fill_idx = fill_addr[TAG_LO-1:IDX_LO];

  assign hit = valid_q[req_idx] && (tag_q[req_idx] == req.pc[AW-1:TAG_LO]);

  assign rsp.hit  = req.en && hit;
  assign rsp.inst = data_q[req_idx][req_off];

  // fill request stays up until the controller reports done
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      valid_q   <= '0;
      fill_en   <= 1'b0;
      fill_addr <= '0;
    end else if (rdy_in) begin
      if (fill_done) begin
        valid_q[fill_idx] <= 1'b1;
        fill_en           <= 1'b0;
      end else if (!fill_en && req.en && !hit) begin
        fill_en   <= 1'b1;
        fill_addr <= {req.pc[AW-1:IDX_LO], {IDX_LO{1'b0}}};  // block aligned
      end
    end
  end

  always_ff @(posedge clk_in) begin
    if (rdy_in && fill_done) begin
      data_q[fill_idx] <= fill_block;
      tag_q[fill_idx]  <= fill_addr[AW-1:TAG_LO];
    end
  end

endmodule

/* verilog/mem_controller.sv */
// byte-serial block reader on the 8-bit ram bus
`timescale 1ns/1ps

module mem_controller #(
  parameter int ADDR_WIDTH    = fetch_pkg::ADDR_WIDTH,
  parameter int MEM_ADDR_BITS = fetch_pkg::MEM_ADDR_BITS
) (
  input  logic                  clk_in,
  input  logic                  rst_in,
  input  logic                  rdy_in,
  input  logic                  fill_en,
  input  logic [ADDR_WIDTH-1:0] fill_addr,
  output logic                  fill_done,
  output fetch_pkg::block_t     fill_block,
  input  logic [7:0]            mem_din,
  output logic [ADDR_WIDTH-1:0] mem_a
);

  localparam int BYTES = $bits(fetch_pkg::block_t) / 8;
  localparam int CNT_W = $clog2(BYTES + 2);

  logic                  busy_q;
  logic [CNT_W-1:0]      cnt_q;   // edges since the fill was taken
  logic [ADDR_WIDTH-1:0] base_q;
  logic [8*BYTES-1:0]    data_q;
  logic [ADDR_WIDTH-1:0] step_a;
  logic [ADDR_WIDTH-1:0] ram_a;

  assign fill_block = data_q;

  // first byte comes straight from the request
  assign step_a = busy_q ? base_q + ADDR_WIDTH'(cnt_q) : fill_addr;

  always_comb begin
    ram_a = '0;
    ram_a[MEM_ADDR_BITS-1:0] = step_a[MEM_ADDR_BITS-1:0];  // only the ram window
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy_q    <= 1'b0;
      cnt_q     <= '0;
      fill_done <= 1'b0;
      mem_a     <= '0;
    end else if (rdy_in) begin
      fill_done <= 1'b0;
      if (!busy_q) begin
        // fill_en is still high during the done cycle
        if (fill_en && !fill_done) begin
          busy_q <= 1'b1;
          cnt_q  <= CNT_W'(1);
          mem_a  <= ram_a;
        end
      end else begin
        cnt_q <= cnt_q + 1'b1;
        if (cnt_q < BYTES) begin
          mem_a <= ram_a;
        end
        if (cnt_q == BYTES + 1) begin
          busy_q    <= 1'b0;
          fill_done <= 1'b1;  // last byte lands with this edge
        end
      end
    end
  end

  // byte k arrives two edges after its address was issued
  always_ff @(posedge clk_in) begin
    if (rdy_in) begin
      if (!busy_q && fill_en && !fill_done) begin
        base_q <= fill_addr;
      end
      if (busy_q && cnt_q >= 2) begin
        data_q[8*(cnt_q-2) +: 8] <= mem_din;  // little endian
      end
    end
  end

endmodule

/* verilog/fetch_pkg.sv */
// front end widths, rv32i opcodes, instruction format union, module structs, immediate helpers
package fetch_pkg;

  localparam int ADDR_WIDTH    = 32;
  localparam int MEM_ADDR_BITS = 17;  // 128 KB ram window
  localparam int BLOCK_WIDTH   = 1;   // log2 instructions per block
  localparam int CACHE_WIDTH   = 8;   // log2 blocks
  localparam int PRED_WIDTH    = 8;   // log2 counters
  localparam logic [ADDR_WIDTH-1:0] RESET_PC = '0;

  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_REG    = 7'b0110011;

  // the six rv32i layouts, msb first
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm_11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } inst_word_u;

  // element 0 sits at the lower address
  typedef inst_word_u [(1 << BLOCK_WIDTH)-1:0] block_t;

  typedef struct packed {
    logic                  en;
    logic [ADDR_WIDTH-1:0] pc;
  } fetch_req_t;

  typedef struct packed {
    logic       hit;
    inst_word_u inst;
  } fetch_rsp_t;

  typedef struct packed {
    logic                  fb_en;
    logic [ADDR_WIDTH-1:0] fb_pc;
    logic                  fb_taken;
  } feedback_t;

  typedef struct packed {
    logic                  en;
    logic [ADDR_WIDTH-1:0] pc;
  } redirect_t;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] pc;
    inst_word_u            inst;
    logic                  pred_taken;
  } fetched_t;

  typedef struct packed {
    logic [ADDR_WIDTH-1:0] pc;
    logic [6:0]            opcode;
    logic [2:0]            funct3;
    logic [6:0]            funct7;
    logic [4:0]            rd;
    logic [4:0]            rs1;
    logic [4:0]            rs2;
    logic [31:0]           imm;
    logic                  pred_taken;
  } decoded_t;

  // sign-extended immediates
  function automatic logic [31:0] imm_i(inst_word_u w);
    return {{20{w.i.imm_11_0[11]}}, w.i.imm_11_0};
  endfunction

  function automatic logic [31:0] imm_s(inst_word_u w);
    return {{20{w.s.imm_11_5[6]}}, w.s.imm_11_5, w.s.imm_4_0};
  endfunction

  function automatic logic [31:0] imm_b(inst_word_u w);
    return {{20{w.b.imm_12}}, w.b.imm_11, w.b.imm_10_5, w.b.imm_4_1, 1'b0};
  endfunction

  function automatic logic [31:0] imm_u(inst_word_u w);
    return {w.u.imm_31_12, 12'b0};
  endfunction

  function automatic logic [31:0] imm_j(inst_word_u w);
    return {{12{w.j.imm_20}}, w.j.imm_19_12, w.j.imm_11, w.j.imm_10_1, 1'b0};
  endfunction

endpackage
